/* ifu_consts.svh */
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// data and address width
`define IFU_XLEN 32
// one compressed parcel
`define IFU_HALF 16

// addi x0,x0,0
`define IFU_NOP 32'h0000_0013

// trap bus width and slots, same numbering as the riscv cause codes
`define IFU_TRAP_LEN 16
`define IFU_TRAP_INST_MISALIGNED 0
`define IFU_TRAP_INST_ACCESS_FAULT 1
`define IFU_TRAP_INST_PAGE_FAULT 12

// rv32i opcodes and funct fields for the expanded forms
`define IFU_OP_IMM 7'b0010011
`define IFU_OP_REG 7'b0110011
`define IFU_F3_ADD 3'b000
`define IFU_F7_ADD 7'b0000000
`define IFU_REG_X0 5'd0

// compressed quadrants and funct fields
`define IFU_C_Q1 2'b01
`define IFU_C_Q2 2'b10
`define IFU_C_F3_ADDI 3'b000
`define IFU_C_F3_LI 3'b010
`define IFU_C_F4_MV 4'b1000
`define IFU_C_F4_ADD 4'b1001

`endif

/* ifu_pkg.sv */
`include "ifu_consts.svh"

package ifu_pkg;

    // ci format view
    // c.addi / c.li and friends
    typedef struct packed {
        logic [2:0] funct3;
        // imm[5], sign bit of the 6-bit immediate
        logic       imm_5;
        logic [4:0] rd_rs1;
        logic [4:0] imm_4_0;
        logic [1:0] quadrant;
    } rvc_ci_t;

    // cr format view
    // c.mv / c.add / c.jr / c.jalr share it
    typedef struct packed {
        logic [3:0] funct4;
        logic [4:0] rd_rs1;
        logic [4:0] rs2;
        logic [1:0] quadrant;
    } rvc_cr_t;

    // one compressed halfword, decoded either way
    typedef union packed {
        rvc_ci_t ci;
        rvc_cr_t cr;
    } rvc_half_u;

    // trap bus from the fetch stage
    // bit positions follow the IFU_TRAP_* slots
    typedef logic [`IFU_TRAP_LEN-1:0] trap_bus_t;

endpackage

/* fetch_aligner.sv */
`include "ifu_consts.svh"

module fetch_aligner (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 if_flush_i,
    input  logic                 if_rdata_valid_i,
    input  logic [`IFU_XLEN-1:0] inst_addr_i,
    input  logic [`IFU_XLEN-1:0] if_rdata_i,
    output logic [`IFU_XLEN-1:0] sel_inst_o,
    output logic                 sel_compressed_o,
    output logic                 sel_valid_o
);

    // halfword addressed by the pc
    logic [`IFU_HALF-1:0] cur_half;
    logic                 cur_compressed;

    // first half of a split 32-bit instruction
    logic [`IFU_HALF-1:0] saved_half;
    // word index of the split, pc >> 2
    logic [`IFU_XLEN-3:0] saved_word;
    logic                 saved_valid;

    logic [`IFU_XLEN-3:0] next_word;
    logic                 join_hit;
    logic                 split_save;

    // bit 1 picks the parcel inside the fetch word
    assign cur_half = inst_addr_i[1] ? if_rdata_i[`IFU_XLEN-1:`IFU_HALF]
                                     : if_rdata_i[`IFU_HALF-1:0];

    // low bits 11 mean a full 32-bit instruction
    assign cur_compressed = (cur_half[1:0] != 2'b11);

    // second half must come from the very next word
    assign next_word = saved_word + 1'b1;
    assign join_hit  = saved_valid && if_rdata_valid_i &&
                       (inst_addr_i[`IFU_XLEN-1:2] == next_word);

    // uncompressed at pc[1]=1 runs into the next word
    // saved flag blocks a second save of a repeated word
    assign split_save = !if_flush_i && !saved_valid && if_rdata_valid_i &&
                        !cur_compressed && inst_addr_i[1];

    // saved flag
    // flush wins over save and join
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            saved_valid <= 1'b0;
        end else if (if_flush_i) begin
            saved_valid <= 1'b0;
        end else if (split_save) begin
            saved_valid <= 1'b1;
        end else if (join_hit) begin
            // joined this cycle, nothing left pending
            saved_valid <= 1'b0;
        end
    end

    // payload only, qualified by saved_valid
    always_ff @(posedge clk) begin
        if (split_save) begin
            saved_half <= cur_half;
            saved_word <= inst_addr_i[`IFU_XLEN-1:2];
        end
    end

    // instruction selection
    always_comb begin
        sel_inst_o       = `IFU_NOP;
        sel_compressed_o = 1'b0;
        sel_valid_o      = 1'b0;
        if (saved_valid) begin
            // waiting on the upper half
            if (join_hit) begin
                sel_inst_o  = {if_rdata_i[`IFU_HALF-1:0], saved_half};
                sel_valid_o = 1'b1;
            end
        end else if (if_rdata_valid_i) begin
            if (cur_compressed) begin
                // expander reads the low half
                sel_inst_o       = {{`IFU_HALF{1'b0}}, cur_half};
                sel_compressed_o = 1'b1;
                sel_valid_o      = 1'b1;
            end else if (!inst_addr_i[1]) begin
                // aligned full word
                sel_inst_o  = if_rdata_i;
                sel_valid_o = 1'b1;
            end
            // else split, halfword gets saved at the edge
        end
    end

endmodule

/* rvc_expander.sv */
`include "ifu_consts.svh"

module rvc_expander (
    input  ifu_pkg::rvc_half_u   half_i,
    output logic [`IFU_XLEN-1:0] inst_o
);

    // 6-bit ci immediate, sign-extended to 12
    logic [11:0] ci_imm;
    // rs2 = x0 would be c.jr / c.jalr
    logic        rs2_nz;

    assign ci_imm = {{6{half_i.ci.imm_5}}, half_i.ci.imm_5, half_i.ci.imm_4_0};
    assign rs2_nz = (half_i.cr.rs2 != `IFU_REG_X0);

    // quadrant and funct decode
    // unsupported patterns leave the illegal all-zero word
    always_comb begin
        inst_o = '0;
        case (half_i.ci.quadrant)
            `IFU_C_Q1: begin
                if (half_i.ci.funct3 == `IFU_C_F3_ADDI) begin
                    // c.addi -> addi rd, rd, imm
                    inst_o = {ci_imm,
                              half_i.ci.rd_rs1,
                              `IFU_F3_ADD,
                              half_i.ci.rd_rs1,
                              `IFU_OP_IMM};
                end else if (half_i.ci.funct3 == `IFU_C_F3_LI) begin
                    // c.li -> addi rd, x0, imm
                    inst_o = {ci_imm,
                              `IFU_REG_X0,
                              `IFU_F3_ADD,
                              half_i.ci.rd_rs1,
                              `IFU_OP_IMM};
                end
            end
            `IFU_C_Q2: begin
                // cr view from here
                if (rs2_nz) begin
                    if (half_i.cr.funct4 == `IFU_C_F4_MV) begin
                        // c.mv -> add rd, x0, rs2
                        inst_o = {`IFU_F7_ADD,
                                  half_i.cr.rs2,
                                  `IFU_REG_X0,
                                  `IFU_F3_ADD,
                                  half_i.cr.rd_rs1,
                                  `IFU_OP_REG};
                    end else if (half_i.cr.funct4 == `IFU_C_F4_ADD) begin
                        // c.add -> add rd, rd, rs2
                        inst_o = {`IFU_F7_ADD,
                                  half_i.cr.rs2,
                                  half_i.cr.rd_rs1,
                                  `IFU_F3_ADD,
                                  half_i.cr.rd_rs1,
                                  `IFU_OP_REG};
                    end
                end
            end
            default: begin
                // quadrant 0 and non-compressed, not expanded
                inst_o = '0;
            end
        endcase
    end

endmodule

/* ifu_output.sv */
`include "ifu_consts.svh"

module ifu_output (
    input  logic [`IFU_XLEN-1:0] sel_inst_i,
    input  logic [`IFU_XLEN-1:0] expanded_inst_i,
    input  logic                 sel_compressed_i,
    input  logic                 sel_valid_i,
    input  logic                 ls_valid_i,
    input  logic                 mmu_page_fault_i,
    input  logic                 mmu_resp_valid_i,
    output logic [`IFU_XLEN-1:0] inst_data_o,
    output logic                 is_compressed_o,
    output logic                 ram_stall_o,
    output ifu_pkg::trap_bus_t   trap_bus_o
);

    import ifu_pkg::*;

    trap_bus_t trap_d;
    // fault only counts with a live mmu response
    logic      page_fault;

    assign page_fault = mmu_page_fault_i && mmu_resp_valid_i;

    // nop fill when nothing complete is available
    assign inst_data_o = !sel_valid_i     ? `IFU_NOP :
                         sel_compressed_i ? expanded_inst_i : sel_inst_i;

    assign is_compressed_o = sel_compressed_i;

    // stall the pipe while no instruction is ready
    // load/store owning memory masks the request
    assign ram_stall_o = !ls_valid_i && !sel_valid_i;

    // trap bus assembly
    always_comb begin
        trap_d = '0;
        // no misaligned or access faults raised here
        trap_d[`IFU_TRAP_INST_MISALIGNED]   = 1'b0;
        trap_d[`IFU_TRAP_INST_ACCESS_FAULT] = 1'b0;
        trap_d[`IFU_TRAP_INST_PAGE_FAULT]   = page_fault;
    end

    assign trap_bus_o = trap_d;

endmodule

/* ifu.sv */
`include "ifu_consts.svh"

module ifu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`IFU_XLEN-1:0] inst_addr_i,
    input  logic [`IFU_XLEN-1:0] if_rdata_i,
    input  logic                 if_rdata_valid_i,
    input  logic                 if_flush_i,
    input  logic                 ls_valid_i,
    input  logic                 mmu_page_fault_i,
    input  logic                 mmu_resp_valid_i,
    output logic [`IFU_XLEN-1:0] inst_addr_o,
    output logic [`IFU_XLEN-1:0] inst_data_o,
    output logic                 is_compressed_o,
    output logic                 ram_stall_o,
    output ifu_pkg::trap_bus_t   trap_bus_o
);

    // aligner to output stage
    logic [`IFU_XLEN-1:0] sel_inst;
    logic                 sel_compressed;
    logic                 sel_valid;
    // 32-bit form of the low halfword
    logic [`IFU_XLEN-1:0] expanded_inst;

    // pc goes straight through to if/id
    assign inst_addr_o = inst_addr_i;

    // halfword tracking and instruction pick
    fetch_aligner fetch_aligner_i (
        .clk              (clk),
        .rst              (rst),
        .if_flush_i       (if_flush_i),
        .if_rdata_valid_i (if_rdata_valid_i),
        .inst_addr_i      (inst_addr_i),
        .if_rdata_i       (if_rdata_i),
        .sel_inst_o       (sel_inst),
        .sel_compressed_o (sel_compressed),
        .sel_valid_o      (sel_valid)
    );

    // compressed parcel sits in the low half
    rvc_expander rvc_expander_i (
        .half_i (sel_inst[`IFU_HALF-1:0]),
        .inst_o (expanded_inst)
    );

    // final mux, stall request, traps
    ifu_output ifu_output_i (
        .sel_inst_i       (sel_inst),
        .expanded_inst_i  (expanded_inst),
        .sel_compressed_i (sel_compressed),
        .sel_valid_i      (sel_valid),
        .ls_valid_i       (ls_valid_i),
        .mmu_page_fault_i (mmu_page_fault_i),
        .mmu_resp_valid_i (mmu_resp_valid_i),
        .inst_data_o      (inst_data_o),
        .is_compressed_o  (is_compressed_o),
        .ram_stall_o      (ram_stall_o),
        .trap_bus_o       (trap_bus_o)
    );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk_o
);

    // period of 40, first rising edge at 20
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

endmodule

/* ifu_props.sv */
`include "ifu_consts.svh"

module ifu_props (
    input logic                 clk,
    input logic                 rst,
    input logic [`IFU_XLEN-1:0] inst_addr_i,
    input logic [`IFU_XLEN-1:0] if_rdata_i,
    input logic                 if_rdata_valid_i,
    input logic                 if_flush_i,
    input logic                 ls_valid_i,
    input logic                 mmu_page_fault_i,
    input logic                 mmu_resp_valid_i,
    input logic [`IFU_XLEN-1:0] inst_addr_out_i,
    input logic [`IFU_XLEN-1:0] inst_data_i,
    input logic                 is_compressed_i,
    input logic                 ram_stall_i,
    input ifu_pkg::trap_bus_t   trap_bus_i
);

    import ifu_pkg::*;

    // tally of failed checks
    int unsigned fail_count = 0;

    // expected split state, tracked from the fetch stream only
    logic                 pend;
    logic [`IFU_HALF-1:0] pend_half;
    logic [`IFU_XLEN-3:0] pend_word;

    logic [`IFU_HALF-1:0] cur_half;
    logic                 cur_full;
    logic                 split;
    logic                 join_now;

    // 32-bit form of a compressed halfword, zero when unsupported
    function automatic logic [`IFU_XLEN-1:0] expected_expand(
        input logic [`IFU_HALF-1:0] h
    );
        logic [11:0] imm;
        logic        q1;
        logic        q2;
        imm = {{7{h[12]}}, h[6:2]};
        q1  = (h[1:0] == `IFU_C_Q1);
        // rs2 of x0 is a jump, not mv/add
        q2  = (h[1:0] == `IFU_C_Q2) && (h[6:2] != `IFU_REG_X0);
        if (q1 && h[15:13] == `IFU_C_F3_ADDI)
            return {imm, h[11:7], `IFU_F3_ADD, h[11:7], `IFU_OP_IMM};
        if (q1 && h[15:13] == `IFU_C_F3_LI)
            return {imm, `IFU_REG_X0, `IFU_F3_ADD, h[11:7], `IFU_OP_IMM};
        if (q2 && h[15:12] == `IFU_C_F4_MV)
            return {`IFU_F7_ADD, h[6:2], `IFU_REG_X0, `IFU_F3_ADD, h[11:7], `IFU_OP_REG};
        if (q2 && h[15:12] == `IFU_C_F4_ADD)
            return {`IFU_F7_ADD, h[6:2], h[11:7], `IFU_F3_ADD, h[11:7], `IFU_OP_REG};
        return '0;
    endfunction

    task automatic count_failure(input string what);
        fail_count++;
        $error("Error at %0t: %s", $time, what);
    endtask

    assign cur_half = inst_addr_i[1] ? if_rdata_i[`IFU_XLEN-1:`IFU_HALF]
                                     : if_rdata_i[`IFU_HALF-1:0];
    assign cur_full = (cur_half[1:0] == 2'b11);
    // full instruction starting in the upper parcel
    assign split    = !pend && if_rdata_valid_i && cur_full && inst_addr_i[1];
    assign join_now = pend && if_rdata_valid_i &&
                      (inst_addr_i[`IFU_XLEN-1:2] == pend_word + 1'b1);

    // flush beats everything
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (if_flush_i) begin
            pend <= 1'b0;
        end else if (split) begin
            pend      <= 1'b1;
            pend_half <= cur_half;
            pend_word <= inst_addr_i[`IFU_XLEN-1:2];
        end else if (join_now) begin
            pend <= 1'b0;
        end
    end

    // pc handed on to decode unchanged
    a_addr: assert property (@(posedge clk) disable iff (rst)
        inst_addr_out_i == inst_addr_i)
        else count_failure("fetch address not passed through");

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        (!pend && if_rdata_valid_i && !inst_addr_i[1] && cur_full) |->
        (inst_data_i == if_rdata_i && !is_compressed_i && !ram_stall_i))
        else count_failure("aligned word not passed through");

    a_compressed: assert property (@(posedge clk) disable iff (rst)
        (!pend && if_rdata_valid_i && !cur_full) |->
        (inst_data_i == expected_expand(cur_half) && is_compressed_i && !ram_stall_i))
        else count_failure("wrong expansion of compressed halfword");

    // first half only, nothing to issue yet
    a_split: assert property (@(posedge clk) disable iff (rst)
        split |-> (inst_data_i == `IFU_NOP && ram_stall_i == !ls_valid_i))
        else count_failure("split cycle did not give nop and stall");

    a_join: assert property (@(posedge clk) disable iff (rst)
        join_now |->
        (inst_data_i == {if_rdata_i[`IFU_HALF-1:0], pend_half} && !is_compressed_i &&
         !ram_stall_i))
        else count_failure("joined instruction wrong");

    // no data, or still waiting on the upper half
    a_no_inst: assert property (@(posedge clk) disable iff (rst)
        (!if_rdata_valid_i || (pend && !join_now)) |->
        (inst_data_i == `IFU_NOP && ram_stall_i == !ls_valid_i))
        else count_failure("nop or stall request wrong without instruction");

    a_trap: assert property (@(posedge clk) disable iff (rst)
        trap_bus_i == ((mmu_page_fault_i && mmu_resp_valid_i) ?
                       trap_bus_t'(1) << `IFU_TRAP_INST_PAGE_FAULT : '0))
        else count_failure("trap bus wrong");

endmodule

bind ifu ifu_props ifu_props_i (
    .inst_addr_out_i (inst_addr_o),
    .inst_data_i     (inst_data_o),
    .is_compressed_i (is_compressed_o),
    .ram_stall_i     (ram_stall_o),
    .trap_bus_i      (trap_bus_o),
    .*
);

/* tb_ifu.sv */
`include "ifu_consts.svh"

module tb_ifu;

    import ifu_pkg::*;

    localparam int stim_cycles = 29;
    // reset, stimulus and slack, in clock periods
    localparam int run_limit   = (16 + stim_cycles + 20) * 40;

    logic                 clk;
    logic                 rst;
    logic [`IFU_XLEN-1:0] inst_addr_i;
    logic [`IFU_XLEN-1:0] if_rdata_i;
    logic                 if_rdata_valid_i;
    logic                 if_flush_i;
    logic                 ls_valid_i;
    logic                 mmu_page_fault_i;
    logic                 mmu_resp_valid_i;
    logic [`IFU_XLEN-1:0] inst_addr_o;
    logic [`IFU_XLEN-1:0] inst_data_o;
    logic                 is_compressed_o;
    logic                 ram_stall_o;
    trap_bus_t            trap_bus_o;

    tb_clk_gen clk_gen_i (.clk_o(clk));

    ifu ifu_i (.*);

    task automatic abort_run(input string why);
        $display("sim failed");
        $fatal(1, "%s", why);
    endtask

    // inputs change 5 after the edge, then wait out the cycle
    task automatic apply_cycle(input logic [31:0] addr, input logic [31:0] data,
                               input logic valid, input logic flush);
        inst_addr_i      = addr;
        if_rdata_i       = data;
        if_rdata_valid_i = valid;
        if_flush_i       = flush;
        // mmu bits wander freely
        mmu_page_fault_i = 1'($urandom);
        mmu_resp_valid_i = 1'($urandom);
        @(posedge clk);
        #5;
    endtask

    // addi, li, mv, add, then a quadrant 0 pattern
    function automatic logic [15:0] make_half(input int kind);
        logic [5:0]  imm;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [15:0] h;
        imm = 6'($urandom);
        rd  = 5'($urandom);
        rs2 = 5'($urandom_range(31, 1));
        case (kind)
            0: h = {`IFU_C_F3_ADDI, imm[5], rd, imm[4:0], `IFU_C_Q1};
            1: h = {`IFU_C_F3_LI, imm[5], rd, imm[4:0], `IFU_C_Q1};
            2: h = {`IFU_C_F4_MV, rd, rs2, `IFU_C_Q2};
            3: h = {`IFU_C_F4_ADD, rd, rs2, `IFU_C_Q2};
            default: h = {14'($urandom), 2'b00};
        endcase
        return h;
    endfunction

    initial begin
        logic [29:0] w;
        logic [15:0] h;
        logic [15:0] other;
        logic [31:0] sw;
        void'($urandom(32'ha7ed));
        w                = 30'h400;
        rst              = 1'b1;
        inst_addr_i      = '0;
        if_rdata_i       = '0;
        if_rdata_valid_i = 1'b0;
        if_flush_i       = 1'b0;
        ls_valid_i       = 1'b0;
        mmu_page_fault_i = 1'b0;
        mmu_resp_valid_i = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        // aligned 32-bit words
        for (int i = 0; i < 4; i++) begin
            apply_cycle({w, 2'b00}, {30'($urandom), 2'b11}, 1'b1, 1'b0);
            w = w + 30'd1;
        end
        // each compressed kind in both parcels
        for (int hi = 0; hi < 2; hi++) begin
            for (int kind = 0; kind < 5; kind++) begin
                h     = make_half(kind);
                // unrelated bits in the parcel not addressed
                other = 16'($urandom);
                apply_cycle({w, hi[0], 1'b0}, hi[0] ? {h, other} : {other, h},
                            1'b1, 1'b0);
                w = w + 30'd1;
            end
        end
        // split, joined by the very next word
        sw = {14'($urandom), 2'b11, 16'($urandom)};
        apply_cycle({w, 2'b10}, sw, 1'b1, 1'b0);
        w = w + 30'd1;
        apply_cycle({w, 2'b00}, $urandom(), 1'b1, 1'b0);
        w = w + 30'd1;
        // split held while the fetcher repeats and idles
        sw = {14'($urandom), 2'b11, 16'($urandom)};
        apply_cycle({w, 2'b10}, sw, 1'b1, 1'b0);
        apply_cycle({w, 2'b10}, sw, 1'b1, 1'b0);
        ls_valid_i = 1'b1;
        apply_cycle({w, 2'b10}, sw, 1'b0, 1'b0);
        ls_valid_i = 1'b0;
        apply_cycle({w, 2'b10}, sw, 1'b0, 1'b0);
        w = w + 30'd1;
        apply_cycle({w, 2'b00}, $urandom(), 1'b1, 1'b0);
        w = w + 30'd1;
        // flush drops the saved half, next word stands alone
        apply_cycle({w, 2'b10}, sw, 1'b1, 1'b0);
        apply_cycle({w, 2'b10}, sw, 1'b0, 1'b1);
        w = w + 30'd1;
        apply_cycle({w, 2'b00}, {30'($urandom), 2'b11}, 1'b1, 1'b0);
        // no data, load/store mask on and off
        for (int i = 0; i < 4; i++) begin
            ls_valid_i = i[0];
            apply_cycle('0, '0, 1'b0, 1'b0);
        end
        ls_valid_i = 1'b0;
        apply_cycle('0, '0, 1'b0, 1'b0);
        if (ifu_i.ifu_props_i.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run("assertion checks failed during the run");
        end
    end

    // stop at the first failed assertion
    initial begin
        wait (ifu_i.ifu_props_i.fail_count != 0);
        abort_run("an assertion on the ifu outputs failed");
    end

    initial begin
        #(run_limit);
        abort_run("watchdog timeout, stimulus did not finish in time");
    end

endmodule

/* build.f */
+incdir+.
ifu_pkg.sv
fetch_aligner.sv
rvc_expander.sv
ifu_output.sv
ifu.sv
tb_clk_gen.sv
ifu_props.sv
tb_ifu.sv

/* Makefile */
SRCS := $(shell grep -v '^+' build.f)

obj_dir/Vtb_ifu: build.f ifu_consts.svh $(SRCS)
	verilator --binary --assert --top-module tb_ifu -f build.f

run: obj_dir/Vtb_ifu
	./obj_dir/Vtb_ifu +verilator+error+limit+1000

clean:
	rm -rf obj_dir

.PHONY: run clean
